//--- dram_defines.svh
`ifndef DRAM_DEFINES_SVH
`define DRAM_DEFINES_SVH

// ------------------------------------------------------------
// data path widths on both the user and the dram side
// ------------------------------------------------------------

// one beat of write or read data
`define DRAM_DATA_W     144
// one enable per byte of the 144-bit beat
`define DRAM_BE_W       18

// flat dram address and the user tag that rides along
`define DRAM_ADDR_W     32
`define DRAM_TAG_W      32

// ------------------------------------------------------------
// queueing
// ------------------------------------------------------------

// bank count must stay 2**BANK_W so the round-robin pointer wraps on its own
`define NUM_BANKS       4
`define BANK_W          2

// entries per bank queue, a power of two
`define BANK_Q_DEPTH    4
// reads in flight plus reads parked for the user, a power of two
`define RD_RET_DEPTH    8

`endif

//--- dram_addr_pkg.sv
`default_nettype none

`include "dram_defines.svh"

package dram_addr_pkg;

    // ------------------------------------------------------------
    // dram address layout
    // ------------------------------------------------------------

    // row on top, bank in the middle, column at the bottom
    // 15 + BANK_W + 15 bits, one 32-bit word
    typedef struct packed {
        logic [14:0]          row;
        logic [`BANK_W-1:0]   bank;
        logic [14:0]          column;
    } dram_addr_fields_t;

    // same word seen two ways
    // the dispatcher sorts on fields.bank, the issuer sends flat
    typedef union packed {
        logic [`DRAM_ADDR_W-1:0]  flat;
        dram_addr_fields_t        fields;
    } dram_addr_u;

endpackage

`default_nettype wire

//--- mem_cmd_pkg.sv
`default_nettype none

`include "dram_defines.svh"

package mem_cmd_pkg;

    // one user command as it moves through the bank queues
    // rnw high for a read, data and be are only meaningful on a write
    typedef struct packed {
        logic                       rnw;
        logic [`DRAM_TAG_W-1:0]     tag;
        dram_addr_pkg::dram_addr_u  addr;
        logic [`DRAM_DATA_W-1:0]    data;
        logic [`DRAM_BE_W-1:0]      be;
    } mem_cmd_t;

    // ------------------------------------------------------------
    // read response back to the user
    // ------------------------------------------------------------

    // tag of the issued read paired with the beat the dram returned
    typedef struct packed {
        logic [`DRAM_TAG_W-1:0]     tag;
        logic [`DRAM_DATA_W-1:0]    data;
    } rd_resp_t;

endpackage

`default_nettype wire

//--- bank_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one command hop with valid/ready
// used from dispatcher into a bank queue and from a bank queue into the issuer
interface bank_req_if;

    // command offered by the source side
    logic                   valid;
    // sink can take it this cycle
    logic                   ready;
    // full command payload, held with valid until the transfer
    mem_cmd_pkg::mem_cmd_t  cmd;

    // side that offers commands
    modport src (
        output valid,
        output cmd,
        input  ready
    );

    // side that takes commands
    modport dst (
        input  valid,
        input  cmd,
        output ready
    );

endinterface

`default_nettype wire

//--- bank_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

// steers each user command into the queue of its bank
// purely combinational, cmd_ready follows the addressed queue
module bank_dispatch (
    input  wire                         cmd_valid,
    output logic                        cmd_ready,
    input  wire mem_cmd_pkg::mem_cmd_t  cmd,
    bank_req_if.src                     banks [`NUM_BANKS]
);

    localparam int NB = `NUM_BANKS;

    // bank field of the incoming address
    logic [`BANK_W-1:0]  sel_bank;
    // per bank view of the handshake
    logic [NB-1:0]       bank_valid;
    logic [NB-1:0]       bank_ready;

    // decode through the field view of the address union
    assign sel_bank = cmd.addr.fields.bank;

    // ------------------------------------------------------------
    // fan out to the bank queues
    // ------------------------------------------------------------
    for (genvar g = 0; g < NB; g++) begin : g_bank
        // only the addressed queue sees valid
        assign bank_valid[g]  = cmd_valid && (sel_bank == g);
        assign banks[g].valid = bank_valid[g];
        // payload goes to every queue, it is ignored without valid
        assign banks[g].cmd   = cmd;
        assign bank_ready[g]  = banks[g].ready;
    end

    // back pressure comes from the addressed queue alone
    // a full queue stalls only its own bank
    assign cmd_ready = bank_ready[sel_bank];

endmodule

`default_nettype wire

//--- bank_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

// per bank command FIFO
// circular register array, valid/ready on both ends
module bank_queue (
    input  wire      dram_clk,
    input  wire      dram_rst,
    bank_req_if.dst  enq,
    bank_req_if.src  deq
);

    localparam int DEPTH = `BANK_Q_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // storage, payload only so no reset
    mem_cmd_pkg::mem_cmd_t  mem [DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    // 0 .. DEPTH, one bit wider than the pointers
    logic [PTR_W:0]    count;

    logic  do_enq;
    logic  do_deq;

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------
    // ready drops only when full
    assign enq.ready = (count != DEPTH);
    // head is visible the cycle after it was written
    assign deq.valid = (count != '0);
    assign deq.cmd   = mem[rd_ptr];

    assign do_enq = enq.valid && enq.ready;
    assign do_deq = deq.valid && deq.ready;

    // ------------------------------------------------------------
    // pointers and fill count
    // ------------------------------------------------------------
    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // depth is a power of two, pointers wrap by overflow
            if (do_enq)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_deq)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge dram_clk) begin
        if (do_enq)
            mem[wr_ptr] <= enq.cmd;
    end

    // a stalled command upstream stays in place, or the per bank order breaks
    a_enq_hold: assert property (@(posedge dram_clk) disable iff (dram_rst)
        enq.valid && !enq.ready |=> enq.valid && $stable(enq.cmd));
    // head entry survives until the issuer takes it
    a_deq_hold: assert property (@(posedge dram_clk) disable iff (dram_rst)
        deq.valid && !deq.ready |=> deq.valid && $stable(deq.cmd));

endmodule

`default_nettype wire

//--- dram_issue_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

// round-robin drain of the bank queues onto the dram command port
// pop happens in the grant cycle, the port fields follow one cycle later
module dram_issue_arb (
    input  wire                          dram_clk,
    input  wire                          dram_rst,
    bank_req_if.dst                      queues [`NUM_BANKS],
    input  wire                          dram_ready,
    input  wire                          rd_credit,
    output logic                         rd_issue,
    output logic [`DRAM_TAG_W-1:0]       rd_issue_tag,
    output logic                         dram_cmd_en,
    output logic                         dram_rnw,
    output logic [`DRAM_ADDR_W-1:0]      dram_address,
    output logic [`DRAM_DATA_W-1:0]      dram_data_o,
    output logic [`DRAM_BE_W-1:0]        dram_byte_enable
);

    localparam int NB = `NUM_BANKS;
    localparam int BW = `BANK_W;

    mem_cmd_pkg::mem_cmd_t  q_cmd [NB];
    logic [NB-1:0]          q_valid;
    logic [NB-1:0]          q_rnw;
    logic [NB-1:0]          eligible;
    logic [NB-1:0]          grant;
    logic [BW-1:0]          grant_idx;
    // queue that has first pick this cycle
    logic [BW-1:0]          rr_ptr;
    logic [BW-1:0]          cand;

    for (genvar g = 0; g < NB; g++) begin : g_q
        assign q_cmd[g]        = queues[g].cmd;
        assign q_valid[g]      = queues[g].valid;
        assign q_rnw[g]        = queues[g].cmd.rnw;
        // ready doubles as the pop
        assign queues[g].ready = grant[g];
    end

    // ------------------------------------------------------------
    // eligibility and round-robin pick
    // ------------------------------------------------------------
    // reads wait for return space, writes never do
    assign eligible = q_valid & ~(q_rnw & {NB{~rd_credit}}) & {NB{dram_ready}};

    always_comb begin
        grant     = '0;
        grant_idx = rr_ptr;
        cand      = rr_ptr;
        // scan from rr_ptr upward, NB is 2**BW so the sum wraps
        for (int i = 0; i < NB; i++) begin
            cand = rr_ptr + BW'(i);
            if (grant == '0 && eligible[cand]) begin
                grant[cand] = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    // tag goes to read_return in the grant cycle so credit is current next cycle
    assign rd_issue     = (grant != '0) && q_cmd[grant_idx].rnw;
    assign rd_issue_tag = q_cmd[grant_idx].tag;

    // ------------------------------------------------------------
    // pointer and registered dram port
    // ------------------------------------------------------------
    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            rr_ptr      <= '0;
            dram_cmd_en <= 1'b0;
        end else begin
            // winner moves to the back of the line
            if (grant != '0)
                rr_ptr <= grant_idx + 1'b1;
            dram_cmd_en <= (grant != '0);
        end
    end

    always_ff @(posedge dram_clk) begin
        if (grant != '0) begin
            dram_rnw         <= q_cmd[grant_idx].rnw;
            dram_address     <= q_cmd[grant_idx].addr.flat;
            dram_data_o      <= q_cmd[grant_idx].data;
            dram_byte_enable <= q_cmd[grant_idx].be;
        end
    end

    // one pop per cycle and only toward a ready controller
    a_grant_onehot: assert property (@(posedge dram_clk) disable iff (dram_rst)
        $onehot0(grant) && (grant == '0 || dram_ready));
    // port stays quiet in the first cycle out of reset
    a_quiet_after_rst: assert property (@(posedge dram_clk)
        dram_rst |=> !dram_cmd_en);

endmodule

`default_nettype wire

//--- read_return.sv
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

// pairs returning read beats with the tags of the issued reads
// tag FIFO fills at issue, data FIFO fills at dram_data_valid, both pop together
module read_return (
    input  wire                          dram_clk,
    input  wire                          dram_rst,
    input  wire                          rd_issue,
    input  wire [`DRAM_TAG_W-1:0]        rd_issue_tag,
    output logic                         rd_credit,
    input  wire [`DRAM_DATA_W-1:0]       dram_data_i,
    input  wire                          dram_data_valid,
    output logic                         rd_valid,
    input  wire                          rd_ready,
    output mem_cmd_pkg::rd_resp_t        resp
);

    localparam int DEPTH = `RD_RET_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`DRAM_TAG_W-1:0]   tag_mem  [DEPTH];
    logic [`DRAM_DATA_W-1:0]  data_mem [DEPTH];

    logic [PTR_W-1:0]  tag_wr_ptr;
    logic [PTR_W-1:0]  data_wr_ptr;
    // heads line up, one read pointer serves both
    logic [PTR_W-1:0]  rd_ptr;
    // tag_count covers reads in flight plus beats waiting for the user
    logic [PTR_W:0]    tag_count;
    logic [PTR_W:0]    data_count;
    logic              pop;

    // a beat is ready once its data is in, its tag is always older
    assign rd_valid  = (data_count != '0);
    assign pop       = rd_valid && rd_ready;
    assign rd_credit = (tag_count < DEPTH);
    assign resp.tag  = tag_mem[rd_ptr];
    assign resp.data = data_mem[rd_ptr];

    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            tag_wr_ptr  <= '0;
            data_wr_ptr <= '0;
            rd_ptr      <= '0;
            tag_count   <= '0;
            data_count  <= '0;
        end else begin
            tag_wr_ptr  <= tag_wr_ptr + PTR_W'(rd_issue);
            data_wr_ptr <= data_wr_ptr + PTR_W'(dram_data_valid);
            rd_ptr      <= rd_ptr + PTR_W'(pop);
            tag_count   <= tag_count + (PTR_W+1)'(rd_issue) - (PTR_W+1)'(pop);
            data_count  <= data_count + (PTR_W+1)'(dram_data_valid) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge dram_clk) begin
        if (rd_issue)
            tag_mem[tag_wr_ptr] <= rd_issue_tag;
        if (dram_data_valid)
            data_mem[data_wr_ptr] <= dram_data_i;
    end

    // every beat from the controller must have an issued read waiting for it
    a_data_has_tag: assert property (@(posedge dram_clk) disable iff (dram_rst)
        dram_data_valid |-> (tag_count > data_count));

endmodule

`default_nettype wire

//--- dram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

// bank-sorted bridge from the user memory port to the dram native port
module dram_bridge (
    input  wire                          dram_clk,
    input  wire                          dram_rst,
    // user command port
    input  wire                          cmd_valid,
    output logic                         cmd_ready,
    input  wire                          cmd_rnw,
    input  wire [`DRAM_ADDR_W-1:0]       cmd_addr,
    input  wire [`DRAM_TAG_W-1:0]        cmd_tag,
    input  wire [`DRAM_DATA_W-1:0]       cmd_data,
    input  wire [`DRAM_BE_W-1:0]         cmd_be,
    // user read return
    output logic                         rd_valid,
    input  wire                          rd_ready,
    output logic [`DRAM_TAG_W-1:0]       rd_tag,
    output logic [`DRAM_DATA_W-1:0]      rd_data,
    // dram native port
    output logic                         dram_cmd_en,
    output logic                         dram_rnw,
    output logic [`DRAM_ADDR_W-1:0]      dram_address,
    output logic [`DRAM_DATA_W-1:0]      dram_data_o,
    output logic [`DRAM_BE_W-1:0]        dram_byte_enable,
    input  wire                          dram_ready,
    input  wire [`DRAM_DATA_W-1:0]       dram_data_i,
    input  wire                          dram_data_valid
);

    mem_cmd_pkg::mem_cmd_t   user_cmd;
    mem_cmd_pkg::rd_resp_t   user_resp;
    logic                    rd_credit;
    logic                    rd_issue;
    logic [`DRAM_TAG_W-1:0]  rd_issue_tag;

    // dispatcher side and issuer side of each bank queue
    bank_req_if q_in  [`NUM_BANKS] ();
    bank_req_if q_out [`NUM_BANKS] ();

    // ------------------------------------------------------------
    // pack the user port, unpack the response
    // ------------------------------------------------------------
    assign user_cmd.rnw       = cmd_rnw;
    assign user_cmd.tag       = cmd_tag;
    assign user_cmd.addr.flat = cmd_addr;
    assign user_cmd.data      = cmd_data;
    assign user_cmd.be        = cmd_be;
    assign rd_tag             = user_resp.tag;
    assign rd_data            = user_resp.data;

    bank_dispatch u_dispatch (
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (user_cmd),
        .banks     (q_in)
    );

    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank_q
        bank_queue u_queue (
            .dram_clk (dram_clk),
            .dram_rst (dram_rst),
            .enq      (q_in[b]),
            .deq      (q_out[b])
        );
    end

    dram_issue_arb u_issue (
        .dram_clk         (dram_clk),
        .dram_rst         (dram_rst),
        .queues           (q_out),
        .dram_ready       (dram_ready),
        .rd_credit        (rd_credit),
        .rd_issue         (rd_issue),
        .rd_issue_tag     (rd_issue_tag),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_data_o      (dram_data_o),
        .dram_byte_enable (dram_byte_enable)
    );

    read_return u_rd_ret (
        .dram_clk        (dram_clk),
        .dram_rst        (dram_rst),
        .rd_issue        (rd_issue),
        .rd_issue_tag    (rd_issue_tag),
        .rd_credit       (rd_credit),
        .dram_data_i     (dram_data_i),
        .dram_data_valid (dram_data_valid),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .resp            (user_resp)
    );

endmodule

`default_nettype wire

//--- tb_dram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

module tb_dram_bridge;

    localparam int N_RAND     = 200;
    localparam int N_STALL_RD = 12;
    // random run, stalled reads, bank fill writes, the other-bank write and the held write
    localparam int TOTAL_CMDS  = N_RAND + N_STALL_RD + `BANK_Q_DEPTH + 2;
    localparam int TIMEOUT_CYC = TOTAL_CMDS * 40;
    localparam logic [31:0] SEED = 32'h8b18_0ad1;
    localparam logic [`DRAM_BE_W-1:0] FULL_BE = '1;

    logic                     dram_clk        = 1'b0;
    logic                     dram_rst        = 1'b1;
    logic                     cmd_valid       = 1'b0;
    logic                     cmd_ready;
    logic                     cmd_rnw         = 1'b0;
    logic [`DRAM_ADDR_W-1:0]  cmd_addr        = '0;
    logic [`DRAM_TAG_W-1:0]   cmd_tag         = '0;
    logic [`DRAM_DATA_W-1:0]  cmd_data        = '0;
    logic [`DRAM_BE_W-1:0]    cmd_be          = '0;
    logic                     rd_valid;
    logic                     rd_ready        = 1'b0;
    logic [`DRAM_TAG_W-1:0]   rd_tag;
    logic [`DRAM_DATA_W-1:0]  rd_data;
    logic                     dram_cmd_en;
    logic                     dram_rnw;
    logic [`DRAM_ADDR_W-1:0]  dram_address;
    logic [`DRAM_DATA_W-1:0]  dram_data_o;
    logic [`DRAM_BE_W-1:0]    dram_byte_enable;
    logic                     dram_ready      = 1'b0;
    logic [`DRAM_DATA_W-1:0]  dram_data_i     = '0;
    logic                     dram_data_valid = 1'b0;

    // separate generator states for stimulus and the dram model
    logic [31:0]  stim_rng = SEED;
    logic [31:0]  env_rng  = ~SEED;
    logic [`DRAM_TAG_W-1:0]  next_tag = 32'h0000_1000;
    // forced stalls on either side
    logic  dram_hold = 1'b0;
    logic  rd_hold   = 1'b0;

    // scoreboard memory, dram model memory, expected read data by tag
    logic [`DRAM_DATA_W-1:0]  sb_mem   [logic [31:0]];
    logic [`DRAM_DATA_W-1:0]  dram_mem [logic [31:0]];
    logic [`DRAM_DATA_W-1:0]  exp_data [logic [31:0]];
    // dram read pipeline, in issue order
    logic [`DRAM_DATA_W-1:0]  ret_data [$];
    int unsigned              ret_due  [$];
    int unsigned              last_due = 0;

    int unsigned  cycle = 0;
    int unsigned  n_accepted = 0;
    int unsigned  n_issued = 0;
    int unsigned  n_rd_issued = 0;
    int unsigned  n_rd_taken = 0;
    int unsigned  errors = 0;
    int unsigned  err_start = 0;
    int unsigned  n_tests = 0;
    int unsigned  n_failed = 0;

    // previous cycle view for the hold and stall checks
    logic  prev_dram_ready = 1'b0;
    logic  prev_rd_valid = 1'b0;
    logic  prev_rd_ready = 1'b0;
    logic [`DRAM_TAG_W-1:0]   prev_rd_tag = '0;
    logic [`DRAM_DATA_W-1:0]  prev_rd_data = '0;

    dram_bridge DUT (
        .dram_clk         (dram_clk),
        .dram_rst         (dram_rst),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .cmd_rnw          (cmd_rnw),
        .cmd_addr         (cmd_addr),
        .cmd_tag          (cmd_tag),
        .cmd_data         (cmd_data),
        .cmd_be           (cmd_be),
        .rd_valid         (rd_valid),
        .rd_ready         (rd_ready),
        .rd_tag           (rd_tag),
        .rd_data          (rd_data),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_data_o      (dram_data_o),
        .dram_byte_enable (dram_byte_enable),
        .dram_ready       (dram_ready),
        .dram_data_i      (dram_data_i),
        .dram_data_valid  (dram_data_valid)
    );

    // 100 ns period
    always #50 dram_clk = ~dram_clk;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_step(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // 16 addresses, bank from k, row and column spread so every field moves
    function automatic logic [31:0] addr_of(int k);
        logic [31:0] row;
        logic [31:0] bank;
        logic [31:0] col;
        row  = 32'(k / `NUM_BANKS) + 32'd40;
        bank = 32'(k % `NUM_BANKS);
        col  = 32'(k) * 32'd97 + 32'd8;
        return (row << 17) | (bank << 15) | (col & 32'h7fff);
    endfunction

    // content of a location never written, built from the whole address
    function automatic logic [`DRAM_DATA_W-1:0] fill_word(logic [31:0] a);
        return {a, ~a, {a[15:0], a[31:16]}, a ^ 32'hc3a5_5a3c, a[15:0] ^ a[31:16]};
    endfunction

    // byte lanes with a clear enable keep the old value
    function automatic logic [`DRAM_DATA_W-1:0] merge_bytes(logic [`DRAM_DATA_W-1:0] old,
            logic [`DRAM_DATA_W-1:0] wdata, logic [`DRAM_BE_W-1:0] be);
        logic [`DRAM_DATA_W-1:0] res;
        res = old;
        for (int i = 0; i < `DRAM_BE_W; i++) begin
            if (be[i])
                res[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [`DRAM_DATA_W-1:0] rand_beat();
        logic [`DRAM_DATA_W-1:0] d;
        logic [31:0] r;
        d = '0;
        for (int i = 0; i < `DRAM_DATA_W / 16; i++) begin
            r = lcg_step(stim_rng);
            d[i*16 +: 16] = r[31:16];
        end
        return d;
    endfunction

    // called 1 ns after a rising edge
    task automatic drive_cmd(input logic rnw, input logic [31:0] addr,
            input logic [`DRAM_BE_W-1:0] be);
        cmd_valid = 1'b1;
        cmd_rnw   = rnw;
        cmd_addr  = addr;
        cmd_tag   = next_tag;
        cmd_data  = rand_beat();
        cmd_be    = be;
        next_tag  = next_tag + 32'd1;
    endtask

    // valid and payload hold until the edge that takes them
    task automatic wait_accept();
        logic got;
        got = 1'b0;
        while (!got) begin
            @(negedge dram_clk);
            got = cmd_ready;
            @(posedge dram_clk);
            #1;
        end
        cmd_valid = 1'b0;
    endtask

    // everything accepted is issued, returned and taken
    // counters are looked at on the rising edge, where no tb process writes them
    task automatic wait_drain();
        while (n_issued != n_accepted || exp_data.size() != 0 || ret_due.size() != 0)
            @(posedge dram_clk);
        #1;
    endtask

    task automatic start_test();
        err_start = errors;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errors != err_start)
            n_failed++;
        $display("test %s: %s (%0d errors)", name,
                 (errors == err_start) ? "PASS" : "FAIL", errors - err_start);
    endtask

    // ------------------------------------------------------------
    // dram controller model, ready, stall and in-order read return
    // ------------------------------------------------------------
    always @(posedge dram_clk) begin
        logic [31:0] r;
        logic        nxt_dram_ready;
        logic        nxt_rd_ready;
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Simulation failed");
            $finish;
        end else begin
            // stall requests are taken at the edge, the pins move 1 ns later
            r = lcg_step(env_rng);
            nxt_dram_ready = !dram_hold && (r[31:30] != 2'b00);
            nxt_rd_ready   = !rd_hold && (r[29:27] > 3'd1);
            #1;
            dram_ready = nxt_dram_ready;
            rd_ready   = nxt_rd_ready;
            if (ret_due.size() != 0 && cycle >= ret_due[0]) begin
                dram_data_valid = 1'b1;
                dram_data_i     = ret_data.pop_front();
                void'(ret_due.pop_front());
            end else begin
                dram_data_valid = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // monitor at the falling edge, where every signal is settled
    // ------------------------------------------------------------
    always @(negedge dram_clk) begin
        logic [31:0] a;
        logic [`DRAM_DATA_W-1:0] cur;
        int unsigned due;
        if (!dram_rst) begin
            // user accept, reference memory in accept order
            if (cmd_valid && cmd_ready) begin
                a   = cmd_addr;
                cur = sb_mem.exists(a) ? sb_mem[a] : fill_word(a);
                if (cmd_rnw)
                    exp_data[cmd_tag] = cur;
                else
                    sb_mem[a] = merge_bytes(cur, cmd_data, cmd_be);
                n_accepted++;
            end
            // a grant needs dram_ready, the port follows one cycle later
            assert (prev_dram_ready || !dram_cmd_en) else begin
                $display("command reached the dram port at %0t while dram_ready was low", $time);
                errors++;
            end
            if (dram_cmd_en) begin
                a   = dram_address;
                cur = dram_mem.exists(a) ? dram_mem[a] : fill_word(a);
                n_issued++;
                if (dram_rnw) begin
                    n_rd_issued++;
                    // 2 to 6 cycles, never overtaking an older read
                    due = cycle + 2 + ((lcg_step(env_rng) >> 16) % 5);
                    if (due <= last_due)
                        due = last_due + 1;
                    last_due = due;
                    ret_data.push_back(cur);
                    ret_due.push_back(due);
                    assert (n_rd_issued <= n_rd_taken + `RD_RET_DEPTH) else begin
                        $display("mismatch at %0t: %0d reads issued with only %0d taken",
                                 $time, n_rd_issued, n_rd_taken);
                        errors++;
                    end
                end else begin
                    dram_mem[a] = merge_bytes(cur, dram_data_o, dram_byte_enable);
                end
            end
            // a stalled response holds still
            if (prev_rd_valid && !prev_rd_ready) begin
                assert (rd_valid && rd_tag == prev_rd_tag && rd_data == prev_rd_data) else begin
                    $display("mismatch at %0t: response changed under stall, tag %h now %h",
                             $time, prev_rd_tag, rd_tag);
                    errors++;
                end
            end
            if (rd_valid && rd_ready) begin
                assert (exp_data.exists(rd_tag)) else begin
                    $display("read returned with tag %h that is not outstanding", rd_tag);
                    errors++;
                end
                if (exp_data.exists(rd_tag)) begin
                    assert (rd_data == exp_data[rd_tag]) else begin
                        $display("mismatch at %0t: tag %h data %h expected %h",
                                 $time, rd_tag, rd_data, exp_data[rd_tag]);
                        errors++;
                    end
                    exp_data.delete(rd_tag);
                end
                n_rd_taken++;
            end
        end
        prev_dram_ready = dram_ready;
        prev_rd_valid   = rd_valid;
        prev_rd_ready   = rd_ready;
        prev_rd_tag     = rd_tag;
        prev_rd_data    = rd_data;
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [`DRAM_BE_W-1:0] be;
        int unsigned issued_before;
        repeat (16) @(posedge dram_clk);
        #1;
        dram_rst = 1'b0;

        start_test();
        @(negedge dram_clk);
        assert (cmd_ready && !dram_cmd_en && !rd_valid) else begin
            $display("mismatch at %0t: after reset cmd_ready %b dram_cmd_en %b rd_valid %b",
                     $time, cmd_ready, dram_cmd_en, rd_valid);
            errors++;
        end
        @(posedge dram_clk);
        #1;
        end_test("idle after reset");

        // mixed reads and writes, full and partial enables, repeated addresses
        start_test();
        for (int i = 0; i < N_RAND; i++) begin
            r = lcg_step(stim_rng);
            if (r[31:30] == 2'b00) begin
                @(posedge dram_clk);
                #1;
            end
            r2 = lcg_step(stim_rng);
            be = r[29] ? FULL_BE : r2[31:14];
            drive_cmd(r[28], addr_of(int'(r[27:24])), be);
            wait_accept();
        end
        wait_drain();
        end_test("random traffic");

        // user stops taking reads, credit must cap the issued reads
        start_test();
        rd_hold = 1'b1;
        for (int i = 0; i < N_STALL_RD; i++) begin
            drive_cmd(1'b1, addr_of(i), FULL_BE);
            wait_accept();
        end
        repeat (40) @(posedge dram_clk);
        #1;
        assert (n_rd_issued - n_rd_taken == `RD_RET_DEPTH) else begin
            $display("mismatch at %0t: %0d reads in flight, expected %0d",
                     $time, n_rd_issued - n_rd_taken, `RD_RET_DEPTH);
            errors++;
        end
        rd_hold = 1'b0;
        wait_drain();
        end_test("read return back-pressure");

        // controller stalled, bank 0 fills while bank 1 still takes commands
        start_test();
        dram_hold = 1'b1;
        repeat (3) @(posedge dram_clk);
        #1;
        issued_before = n_issued;
        for (int i = 0; i < `BANK_Q_DEPTH; i++) begin
            drive_cmd(1'b0, addr_of(i * `NUM_BANKS), FULL_BE);
            wait_accept();
        end
        drive_cmd(1'b0, addr_of(1), FULL_BE);
        wait_accept();
        drive_cmd(1'b0, addr_of(0), 18'h0_0f0f);
        repeat (8) begin
            @(negedge dram_clk);
            assert (!cmd_ready) else begin
                $display("mismatch at %0t: cmd_ready high with bank 0 full", $time);
                errors++;
            end
        end
        assert (n_issued == issued_before) else begin
            $display("commands were issued while dram_ready was held low");
            errors++;
        end
        @(posedge dram_clk);
        #1;
        dram_hold = 1'b0;
        wait_accept();
        wait_drain();
        assert (n_issued - issued_before == `BANK_Q_DEPTH + 2) else begin
            $display("mismatch at %0t: %0d queued commands issued, expected %0d",
                     $time, n_issued - issued_before, `BANK_Q_DEPTH + 2);
            errors++;
        end
        end_test("dram stall and bank full");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_tests - n_failed, n_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dram_bridge.f
+incdir+.
dram_addr_pkg.sv
mem_cmd_pkg.sv
bank_req_if.sv
bank_dispatch.sv
bank_queue.sv
dram_issue_arb.sv
read_return.sv
dram_bridge.sv
tb_dram_bridge.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_dram_bridge
FILELIST  = dram_bridge.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
